//--- compile.f
+incdir+.
igr_pkg.sv
igr_seg_if.sv
igr_epl_shim.sv
igr_seg_fifo.sv
igr_src_arb.sv
igr_top.sv
tb_igr_top.sv

//--- igr_epl_shim.sv
// igr_epl_shim: input registers, word check, invalid-word masking, pause vector
`default_nettype none

`include "igr_settings.svh"

module igr_epl_shim (
  input  logic                                  clk,
  input  logic                                  rst,
  input  igr_pkg::ecc8_t   [`IGR_WORDS-1:0]     rx_ecc,
  input  igr_pkg::port_num_t                    rx_port_num,
  input  igr_pkg::word_vld_t                    rx_data_v,
  input  igr_pkg::epl_md_t                      rx_md,
  input  igr_pkg::epl_ts_t                      rx_ts,
  input  igr_pkg::data64_t [`IGR_WORDS-1:0]     rx_data,
  input  logic                                  rx_pfc_xoff,
  input  igr_pkg::tc_t                          rx_flow_control_tc,
  igr_seg_if.src                                seg,
  output igr_pkg::pause_vec_t                   pause_tc
);
  import igr_pkg::*;

  // xor of all eight bytes of a word
  function automatic ecc8_t byte_xor(input data64_t w);
    ecc8_t acc;
    acc = '0;
    for (int b = 0; b < 8; b++) begin
      acc = acc ^ w[8*b +: 8];
    end
    return acc;
  endfunction

  data64_t [`IGR_WORDS-1:0] data_m;
  logic                     ecc_err_c;
  logic                     rx_any;

  // a beat exists when at least one word is flagged valid
  assign rx_any = |rx_data_v;

  // --------------------------------------------------
  // check and mask, per word
  // --------------------------------------------------
  always_comb begin
    ecc_err_c = 1'b0;
    for (int w = 0; w < `IGR_WORDS; w++) begin
      data_m[w] = rx_data_v[w] ? rx_data[w] : '0;
      // only valid words count toward the error flag
      if (rx_data_v[w] && (byte_xor(rx_data[w]) != rx_ecc[w])) begin
        ecc_err_c = 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // beat register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      seg.vld <= 1'b0;
    end else begin
      seg.vld <= rx_any;
    end
  end

  // payload only loads with a beat, holds otherwise
  always_ff @(posedge clk) begin
    if (rx_any) begin
      seg.port_num <= rx_port_num;
      seg.md       <= rx_md;
      seg.ts       <= rx_ts;
      seg.data     <= data_m;
      seg.wvld     <= rx_data_v;
      seg.ecc_err  <= ecc_err_c;
    end
  end

  // --------------------------------------------------
  // pause vector, one class updated per cycle
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      pause_tc <= '0;
    end else begin
      pause_tc[rx_flow_control_tc] <= rx_pfc_xoff;
    end
  end

  // the fifo relies on every strobed beat carrying a word
  a_vld_has_word : assert property (@(posedge clk) disable iff (rst)
    seg.vld |-> (seg.wvld != '0));

endmodule

`default_nettype wire

//--- igr_pkg.sv
// igr_pkg: vector typedefs shared across the ingress partition
`default_nettype none

`include "igr_settings.svh"

package igr_pkg;

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------
  typedef logic [63:0] data64_t;
  // xor of the eight bytes of one word
  typedef logic [7:0] ecc8_t;
  typedef logic [`IGR_WORDS-1:0] word_vld_t;

  // --------------------------------------------------
  // per-beat side information
  // --------------------------------------------------
  // port within an epl group
  typedef logic [1:0] port_num_t;
  // carried through untouched
  typedef logic [15:0] epl_md_t;
  typedef logic [31:0] epl_ts_t;

  // --------------------------------------------------
  // flow control and bookkeeping
  // --------------------------------------------------
  typedef logic [2:0] tc_t;
  // one bit per traffic class
  typedef logic [7:0] pause_vec_t;
  typedef logic [2:0] src_id_t;
  // must hold the value IGR_FIFO_DEPTH itself
  typedef logic [$clog2(`IGR_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

endpackage

`default_nettype wire

//--- igr_seg_fifo.sv
// igr_seg_fifo: per-source beat fifo, fill count, drop on full, almost-full flag
`default_nettype none

`include "igr_settings.svh"

module igr_seg_fifo (
  input  logic                clk,
  input  logic                rst,
  igr_seg_if.dst              wr,
  igr_seg_if.src              rd,
  input  logic                pop,
  output igr_pkg::fifo_cnt_t  cnt,
  output logic                almost_full
);
  import igr_pkg::*;

  localparam int DEPTH = `IGR_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  // storage, one array per field
  port_num_t                mem_port [DEPTH];
  epl_md_t                  mem_md   [DEPTH];
  epl_ts_t                  mem_ts   [DEPTH];
  data64_t [`IGR_WORDS-1:0] mem_data [DEPTH];
  word_vld_t                mem_wvld [DEPTH];
  logic                     mem_err  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             do_wr;

  assign full = (cnt == fifo_cnt_t'(DEPTH));
  // full fifo still takes a beat if the head leaves this cycle
  assign do_wr = wr.vld && (!full || pop);

  // --------------------------------------------------
  // write side
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem_port[wr_ptr] <= wr.port_num;
      mem_md[wr_ptr]   <= wr.md;
      mem_ts[wr_ptr]   <= wr.ts;
      mem_data[wr_ptr] <= wr.data;
      mem_wvld[wr_ptr] <= wr.wvld;
      mem_err[wr_ptr]  <= wr.ecc_err;
    end
  end

  // pointers and count
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      cnt         <= '0;
      almost_full <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
      // lags the count by one cycle
      almost_full <= (cnt >= fifo_cnt_t'(`IGR_XOFF_LEVEL));
    end
  end

  // --------------------------------------------------
  // head beat, valid while not empty
  // --------------------------------------------------
  assign rd.vld      = (cnt != '0);
  assign rd.port_num = mem_port[rd_ptr];
  assign rd.md       = mem_md[rd_ptr];
  assign rd.ts       = mem_ts[rd_ptr];
  assign rd.data     = mem_data[rd_ptr];
  assign rd.wvld     = mem_wvld[rd_ptr];
  assign rd.ecc_err  = mem_err[rd_ptr];

  // arbiter must only pop a source it saw as valid
  a_no_pop_empty : assert property (@(posedge clk) disable iff (rst)
    pop |-> (cnt != '0));
  a_cnt_bound : assert property (@(posedge clk) disable iff (rst)
    cnt <= fifo_cnt_t'(DEPTH));

endmodule

`default_nettype wire

//--- igr_seg_if.sv
// igr_seg_if: one checked beat between ingress blocks, src and dst modports
`default_nettype none

`include "igr_settings.svh"

interface igr_seg_if;
  import igr_pkg::*;

  // beat strobe, no ready
  logic vld;
  port_num_t port_num;
  epl_md_t md;
  epl_ts_t ts;
  // invalid words already zeroed by the shim
  data64_t [`IGR_WORDS-1:0] data;
  word_vld_t wvld;
  // some valid word failed its byte-xor check
  logic ecc_err;

  modport src (output vld, port_num, md, ts, data, wvld, ecc_err);
  modport dst (input vld, port_num, md, ts, data, wvld, ecc_err);

endinterface

`default_nettype wire

//--- igr_settings.svh
// ingress sizing macros: words per beat, fifo depth, source count, xoff level
`ifndef IGR_SETTINGS_SVH
`define IGR_SETTINGS_SVH

// 64-bit data words per beat, also the width of the per-word valid mask
`define IGR_WORDS 2

// beats held by each per-source segment fifo
`define IGR_FIFO_DEPTH 4

// sources 0..3 are epl groups a..d, source 4 is the virtual port
`define IGR_NUM_SRC 5

// vp fifo fill count at or above which vp_tx_pfc_xoff is raised
`define IGR_XOFF_LEVEL 3

`endif

//--- igr_src_arb.sv
// igr_src_arb: round-robin merge of the source fifos into one registered ppe beat
`default_nettype none

`include "igr_settings.svh"

module igr_src_arb (
  input  logic                                  clk,
  input  logic                                  rst,
  igr_seg_if.dst                                req [`IGR_NUM_SRC],
  output logic [`IGR_NUM_SRC-1:0]               pop,
  output logic                                  ppe_valid,
  output igr_pkg::src_id_t                      ppe_src,
  output igr_pkg::port_num_t                    ppe_port_num,
  output igr_pkg::epl_md_t                      ppe_md,
  output igr_pkg::epl_ts_t                      ppe_ts,
  output igr_pkg::data64_t [`IGR_WORDS-1:0]     ppe_data,
  output igr_pkg::word_vld_t                    ppe_wvld,
  output logic                                  ppe_ecc_err
);
  import igr_pkg::*;

  localparam int NUM_SRC = `IGR_NUM_SRC;

  // flattened copy of the request interfaces so they can be indexed by gnt
  logic                     req_vld  [NUM_SRC];
  port_num_t                req_port [NUM_SRC];
  epl_md_t                  req_md   [NUM_SRC];
  epl_ts_t                  req_ts   [NUM_SRC];
  data64_t [`IGR_WORDS-1:0] req_data [NUM_SRC];
  word_vld_t                req_wvld [NUM_SRC];
  logic                     req_err  [NUM_SRC];

  src_id_t ptr;
  src_id_t gnt;
  logic    found;

  for (genvar gi = 0; gi < NUM_SRC; gi++) begin : g_req
    assign req_vld[gi]  = req[gi].vld;
    assign req_port[gi] = req[gi].port_num;
    assign req_md[gi]   = req[gi].md;
    assign req_ts[gi]   = req[gi].ts;
    assign req_data[gi] = req[gi].data;
    assign req_wvld[gi] = req[gi].wvld;
    assign req_err[gi]  = req[gi].ecc_err;
  end

  // --------------------------------------------------
  // grant: first valid source at or after ptr
  // --------------------------------------------------
  always_comb begin
    int idx;
    found = 1'b0;
    gnt   = '0;
    for (int off = 0; off < NUM_SRC; off++) begin
      idx = (int'(ptr) + off) % NUM_SRC;
      if (!found && req_vld[idx]) begin
        found = 1'b1;
        gnt   = src_id_t'(idx);
      end
    end
    // pop the winner in the same cycle
    pop = '0;
    if (found) begin
      pop[gnt] = 1'b1;
    end
  end

  // pointer moves past the winner, stays put when idle
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr       <= '0;
      ppe_valid <= 1'b0;
    end else begin
      ppe_valid <= found;
      if (found) begin
        ptr <= (gnt == src_id_t'(NUM_SRC-1)) ? '0 : gnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // output beat toward rx ppe
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (found) begin
      ppe_src      <= gnt;
      ppe_port_num <= req_port[gnt];
      ppe_md       <= req_md[gnt];
      ppe_ts       <= req_ts[gnt];
      ppe_data     <= req_data[gnt];
      ppe_wvld     <= req_wvld[gnt];
      ppe_ecc_err  <= req_err[gnt];
    end
  end

  // at most one fifo drained per cycle
  a_pop_onehot : assert property (@(posedge clk) disable iff (rst)
    $onehot0(pop));

endmodule

`default_nettype wire

//--- igr_top.sv
// igr_top: ingress partition top, five epl shims, five segment fifos, one arbiter
`default_nettype none

`include "igr_settings.svh"

module igr_top (
  input  logic                               clk,
  input  logic                               rst,

  // --------------------------------------------------
  // epl group a
  input  igr_pkg::ecc8_t   [`IGR_WORDS-1:0]  grp_a_rx_ecc,
  input  igr_pkg::port_num_t                 grp_a_rx_port_num,
  input  igr_pkg::word_vld_t                 grp_a_rx_data_valid,
  input  igr_pkg::epl_md_t                   grp_a_rx_metadata,
  input  igr_pkg::epl_ts_t                   grp_a_rx_time_stamp,
  input  igr_pkg::data64_t [`IGR_WORDS-1:0]  grp_a_rx_data,
  input  logic                               grp_a_rx_pfc_xoff,
  input  igr_pkg::tc_t                       grp_a_rx_flow_control_tc,
  // epl group b
  input  igr_pkg::ecc8_t   [`IGR_WORDS-1:0]  grp_b_rx_ecc,
  input  igr_pkg::port_num_t                 grp_b_rx_port_num,
  input  igr_pkg::word_vld_t                 grp_b_rx_data_valid,
  input  igr_pkg::epl_md_t                   grp_b_rx_metadata,
  input  igr_pkg::epl_ts_t                   grp_b_rx_time_stamp,
  input  igr_pkg::data64_t [`IGR_WORDS-1:0]  grp_b_rx_data,
  input  logic                               grp_b_rx_pfc_xoff,
  input  igr_pkg::tc_t                       grp_b_rx_flow_control_tc,
  // epl group c
  input  igr_pkg::ecc8_t   [`IGR_WORDS-1:0]  grp_c_rx_ecc,
  input  igr_pkg::port_num_t                 grp_c_rx_port_num,
  input  igr_pkg::word_vld_t                 grp_c_rx_data_valid,
  input  igr_pkg::epl_md_t                   grp_c_rx_metadata,
  input  igr_pkg::epl_ts_t                   grp_c_rx_time_stamp,
  input  igr_pkg::data64_t [`IGR_WORDS-1:0]  grp_c_rx_data,
  input  logic                               grp_c_rx_pfc_xoff,
  input  igr_pkg::tc_t                       grp_c_rx_flow_control_tc,
  // epl group d
  input  igr_pkg::ecc8_t   [`IGR_WORDS-1:0]  grp_d_rx_ecc,
  input  igr_pkg::port_num_t                 grp_d_rx_port_num,
  input  igr_pkg::word_vld_t                 grp_d_rx_data_valid,
  input  igr_pkg::epl_md_t                   grp_d_rx_metadata,
  input  igr_pkg::epl_ts_t                   grp_d_rx_time_stamp,
  input  igr_pkg::data64_t [`IGR_WORDS-1:0]  grp_d_rx_data,
  input  logic                               grp_d_rx_pfc_xoff,
  input  igr_pkg::tc_t                       grp_d_rx_flow_control_tc,
  // virtual port
  input  igr_pkg::ecc8_t   [`IGR_WORDS-1:0]  vp_rx_ecc,
  input  igr_pkg::port_num_t                 vp_rx_port_num,
  input  igr_pkg::word_vld_t                 vp_rx_data_valid,
  input  igr_pkg::epl_md_t                   vp_rx_metadata,
  input  igr_pkg::epl_ts_t                   vp_rx_time_stamp,
  input  igr_pkg::data64_t [`IGR_WORDS-1:0]  vp_rx_data,
  input  logic                               vp_rx_pfc_xoff,
  input  igr_pkg::tc_t                       vp_rx_flow_control_tc,

  // --------------------------------------------------
  // flow control back to the senders
  output igr_pkg::pause_vec_t                grp_a_pause_tc,
  output igr_pkg::pause_vec_t                grp_b_pause_tc,
  output igr_pkg::pause_vec_t                grp_c_pause_tc,
  output igr_pkg::pause_vec_t                grp_d_pause_tc,
  output logic                               vp_tx_pfc_xoff,

  // --------------------------------------------------
  // toward rx ppe
  output logic                               ppe_valid,
  output igr_pkg::src_id_t                   ppe_src,
  output igr_pkg::port_num_t                 ppe_port_num,
  output igr_pkg::epl_md_t                   ppe_md,
  output igr_pkg::epl_ts_t                   ppe_ts,
  output igr_pkg::data64_t [`IGR_WORDS-1:0]  ppe_data,
  output igr_pkg::word_vld_t                 ppe_wvld,
  output logic                               ppe_ecc_err
);

  // vp is the last source index
  localparam int VP_IDX = `IGR_NUM_SRC - 1;

  igr_seg_if shim_seg [`IGR_NUM_SRC] ();
  igr_seg_if fifo_seg [`IGR_NUM_SRC] ();
  logic [`IGR_NUM_SRC-1:0] fifo_pop;

  // --------------------------------------------------
  // epl shims, index 0..3 = groups a..d
  // --------------------------------------------------
  igr_epl_shim u_shim_a (
    .clk, .rst, .rx_ecc(grp_a_rx_ecc), .rx_port_num(grp_a_rx_port_num),
    .rx_data_v(grp_a_rx_data_valid), .rx_md(grp_a_rx_metadata),
    .rx_ts(grp_a_rx_time_stamp), .rx_data(grp_a_rx_data),
    .rx_pfc_xoff(grp_a_rx_pfc_xoff), .rx_flow_control_tc(grp_a_rx_flow_control_tc),
    .seg(shim_seg[0]), .pause_tc(grp_a_pause_tc)
  );

  igr_epl_shim u_shim_b (
    .clk, .rst, .rx_ecc(grp_b_rx_ecc), .rx_port_num(grp_b_rx_port_num),
    .rx_data_v(grp_b_rx_data_valid), .rx_md(grp_b_rx_metadata),
    .rx_ts(grp_b_rx_time_stamp), .rx_data(grp_b_rx_data),
    .rx_pfc_xoff(grp_b_rx_pfc_xoff), .rx_flow_control_tc(grp_b_rx_flow_control_tc),
    .seg(shim_seg[1]), .pause_tc(grp_b_pause_tc)
  );

  igr_epl_shim u_shim_c (
    .clk, .rst, .rx_ecc(grp_c_rx_ecc), .rx_port_num(grp_c_rx_port_num),
    .rx_data_v(grp_c_rx_data_valid), .rx_md(grp_c_rx_metadata),
    .rx_ts(grp_c_rx_time_stamp), .rx_data(grp_c_rx_data),
    .rx_pfc_xoff(grp_c_rx_pfc_xoff), .rx_flow_control_tc(grp_c_rx_flow_control_tc),
    .seg(shim_seg[2]), .pause_tc(grp_c_pause_tc)
  );

  igr_epl_shim u_shim_d (
    .clk, .rst, .rx_ecc(grp_d_rx_ecc), .rx_port_num(grp_d_rx_port_num),
    .rx_data_v(grp_d_rx_data_valid), .rx_md(grp_d_rx_metadata),
    .rx_ts(grp_d_rx_time_stamp), .rx_data(grp_d_rx_data),
    .rx_pfc_xoff(grp_d_rx_pfc_xoff), .rx_flow_control_tc(grp_d_rx_flow_control_tc),
    .seg(shim_seg[3]), .pause_tc(grp_d_pause_tc)
  );

  // vp pause vector has no consumer
  igr_epl_shim u_shim_vp (
    .clk, .rst, .rx_ecc(vp_rx_ecc), .rx_port_num(vp_rx_port_num),
    .rx_data_v(vp_rx_data_valid), .rx_md(vp_rx_metadata),
    .rx_ts(vp_rx_time_stamp), .rx_data(vp_rx_data),
    .rx_pfc_xoff(vp_rx_pfc_xoff), .rx_flow_control_tc(vp_rx_flow_control_tc),
    .seg(shim_seg[VP_IDX]), .pause_tc()
  );

  // --------------------------------------------------
  // segment fifos
  // --------------------------------------------------
  for (genvar gi = 0; gi < VP_IDX; gi++) begin : g_grp_fifo
    igr_seg_fifo u_fifo (
      .clk, .rst, .wr(shim_seg[gi]), .rd(fifo_seg[gi]),
      .pop(fifo_pop[gi]), .cnt(), .almost_full()
    );
  end

  // vp fill level drives the xoff back to the virtual port
  igr_seg_fifo u_fifo_vp (
    .clk, .rst, .wr(shim_seg[VP_IDX]), .rd(fifo_seg[VP_IDX]),
    .pop(fifo_pop[VP_IDX]), .cnt(), .almost_full(vp_tx_pfc_xoff)
  );

  // --------------------------------------------------
  // round-robin merge toward the parser
  // --------------------------------------------------
  igr_src_arb u_arb (
    .clk, .rst, .req(fifo_seg), .pop(fifo_pop),
    .ppe_valid, .ppe_src, .ppe_port_num, .ppe_md, .ppe_ts,
    .ppe_data, .ppe_wvld, .ppe_ecc_err
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the ingress testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_igr_top -o sim_igr

./obj_dir/sim_igr > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
grep -q '\*\*\* PASSED \*\*\*' sim.log

//--- tb_igr_top.sv
// tb_igr_top: stimulus table, lcg data, per-source scoreboard queues, checks, watchdog
`default_nettype none

`include "igr_settings.svh"

module tb_igr_top;
  import igr_pkg::*;

  localparam int NSRC = `IGR_NUM_SRC;
  localparam int TBL_LEN = 14;

  // one table row is applied in one clock cycle to every source in srcs
  typedef struct packed {
    logic [NSRC-1:0] srcs;
    port_num_t       port;
    epl_md_t         md;
    word_vld_t       mask;
    logic [1:0]      corrupt;
    logic [3:0]      gap;
    logic            exact;
    logic            rr;
  } entry_t;

  // expected beat on the scoreboard
  typedef struct packed {
    port_num_t                port;
    epl_md_t                  md;
    epl_ts_t                  ts;
    data64_t [`IGR_WORDS-1:0] data;
    word_vld_t                wvld;
    logic                     err;
    int                       cyc;
    logic                     exact;
    logic                     rr;
  } exp_t;

  logic clk;
  logic rst;
  ecc8_t   [`IGR_WORDS-1:0] rx_ecc  [NSRC];
  port_num_t                rx_port [NSRC];
  word_vld_t                rx_dv   [NSRC];
  epl_md_t                  rx_md   [NSRC];
  epl_ts_t                  rx_ts   [NSRC];
  data64_t [`IGR_WORDS-1:0] rx_data [NSRC];
  logic                     rx_xoff [NSRC];
  tc_t                      rx_tc   [NSRC];

  pause_vec_t               pause [4];
  logic                     vp_tx_pfc_xoff;
  logic                     ppe_valid;
  src_id_t                  ppe_src;
  port_num_t                ppe_port_num;
  epl_md_t                  ppe_md;
  epl_ts_t                  ppe_ts;
  data64_t [`IGR_WORDS-1:0] ppe_data;
  word_vld_t                ppe_wvld;
  logic                     ppe_ecc_err;

  entry_t  tbl [TBL_LEN];
  exp_t    exp_q [NSRC][$];
  int      errors;
  int      cyc;
  logic [31:0] lcg_state;
  // xoff as seen at the last falling edge and read by the driver at rising edges
  logic    xoff_s;
  logic    xoff_seen;
  // model of the arbiter pointer
  int      rr_ptr;

  igr_top uut (
    .clk, .rst,
    .grp_a_rx_ecc(rx_ecc[0]), .grp_a_rx_port_num(rx_port[0]),
    .grp_a_rx_data_valid(rx_dv[0]), .grp_a_rx_metadata(rx_md[0]),
    .grp_a_rx_time_stamp(rx_ts[0]), .grp_a_rx_data(rx_data[0]),
    .grp_a_rx_pfc_xoff(rx_xoff[0]), .grp_a_rx_flow_control_tc(rx_tc[0]),
    .grp_b_rx_ecc(rx_ecc[1]), .grp_b_rx_port_num(rx_port[1]),
    .grp_b_rx_data_valid(rx_dv[1]), .grp_b_rx_metadata(rx_md[1]),
    .grp_b_rx_time_stamp(rx_ts[1]), .grp_b_rx_data(rx_data[1]),
    .grp_b_rx_pfc_xoff(rx_xoff[1]), .grp_b_rx_flow_control_tc(rx_tc[1]),
    .grp_c_rx_ecc(rx_ecc[2]), .grp_c_rx_port_num(rx_port[2]),
    .grp_c_rx_data_valid(rx_dv[2]), .grp_c_rx_metadata(rx_md[2]),
    .grp_c_rx_time_stamp(rx_ts[2]), .grp_c_rx_data(rx_data[2]),
    .grp_c_rx_pfc_xoff(rx_xoff[2]), .grp_c_rx_flow_control_tc(rx_tc[2]),
    .grp_d_rx_ecc(rx_ecc[3]), .grp_d_rx_port_num(rx_port[3]),
    .grp_d_rx_data_valid(rx_dv[3]), .grp_d_rx_metadata(rx_md[3]),
    .grp_d_rx_time_stamp(rx_ts[3]), .grp_d_rx_data(rx_data[3]),
    .grp_d_rx_pfc_xoff(rx_xoff[3]), .grp_d_rx_flow_control_tc(rx_tc[3]),
    .vp_rx_ecc(rx_ecc[4]), .vp_rx_port_num(rx_port[4]),
    .vp_rx_data_valid(rx_dv[4]), .vp_rx_metadata(rx_md[4]),
    .vp_rx_time_stamp(rx_ts[4]), .vp_rx_data(rx_data[4]),
    .vp_rx_pfc_xoff(rx_xoff[4]), .vp_rx_flow_control_tc(rx_tc[4]),
    .grp_a_pause_tc(pause[0]), .grp_b_pause_tc(pause[1]),
    .grp_c_pause_tc(pause[2]), .grp_d_pause_tc(pause[3]),
    .vp_tx_pfc_xoff,
    .ppe_valid, .ppe_src, .ppe_port_num, .ppe_md, .ppe_ts,
    .ppe_data, .ppe_wvld, .ppe_ecc_err
  );

  always #50 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  always @(negedge clk) begin
    xoff_s <= vp_tx_pfc_xoff;
    if (vp_tx_pfc_xoff) xoff_seen <= 1'b1;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // check code is the xor of the eight bytes of a word
  function automatic ecc8_t word_code(input data64_t w);
    ecc8_t c;
    c = '0;
    for (int b = 0; b < 8; b++) c = c ^ w[8*b +: 8];
    return c;
  endfunction

  task automatic check_val(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s: got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int outstanding();
    int n;
    n = 0;
    for (int s = 0; s < NSRC; s++) n += exp_q[s].size();
    return n;
  endfunction

  task automatic idle_inputs();
    for (int s = 0; s < NSRC; s++) rx_dv[s] <= '0;
  endtask

  // --------------------------------------------------
  // drive one table row and then its gap cycles
  // --------------------------------------------------
  task automatic apply_entry(input entry_t e);
    data64_t [`IGR_WORDS-1:0] w;
    ecc8_t   [`IGR_WORDS-1:0] c;
    exp_t x;
    @(posedge clk);
    // vp sender honours xoff
    while (e.srcs[NSRC-1] && xoff_s) begin
      idle_inputs();
      @(posedge clk);
    end
    for (int s = 0; s < NSRC; s++) begin
      if (e.srcs[s]) begin
        for (int k = 0; k < `IGR_WORDS; k++) begin
          w[k] = {lcg_next(), lcg_next()};
          c[k] = word_code(w[k]) ^ (e.corrupt[k] ? 8'hff : 8'h00);
          x.data[k] = e.mask[k] ? w[k] : '0;
        end
        x.port  = e.port;
        x.md    = e.md ^ epl_md_t'(s);
        x.ts    = lcg_next();
        x.wvld  = e.mask;
        x.err   = |(e.mask & e.corrupt);
        // cyc still holds the count from before this driving edge
        x.cyc   = cyc + 1;
        x.exact = e.exact;
        x.rr    = e.rr;
        rx_dv[s]   <= e.mask;
        rx_port[s] <= e.port;
        rx_md[s]   <= x.md;
        rx_ts[s]   <= x.ts;
        rx_data[s] <= w;
        rx_ecc[s]  <= c;
        exp_q[s].push_back(x);
      end else begin
        rx_dv[s] <= '0;
      end
    end
    for (int g = 0; g < int'(e.gap); g++) begin
      @(posedge clk);
      idle_inputs();
    end
  endtask

  // one group's pause bit follows xoff for its class
  task automatic pause_check(input int g);
    @(posedge clk);
    rx_xoff[g] <= 1'b1;
    rx_tc[g]   <= tc_t'(g + 2);
    @(posedge clk);
    @(negedge clk);
    for (int h = 0; h < 4; h++) begin
      check_val("pause set", pause[h], (h == g) ? (128'd1 << (g + 2)) : 128'd0);
    end
    @(posedge clk);
    rx_xoff[g] <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_val("pause clear", pause[g], 0);
  endtask

  // --------------------------------------------------
  // monitor and scoreboard
  // --------------------------------------------------
  always @(negedge clk) begin
    exp_t x;
    if (!rst && ppe_valid) begin
      if (int'(ppe_src) >= NSRC || exp_q[ppe_src].size() == 0) begin
        errors++;
        $display("unexpected beat from source %0d at time %0t", ppe_src, $time);
      end else begin
        x = exp_q[ppe_src].pop_front();
        check_val("port", ppe_port_num, x.port);
        check_val("md", ppe_md, x.md);
        check_val("ts", ppe_ts, x.ts);
        check_val("data", ppe_data, x.data);
        check_val("wvld", ppe_wvld, x.wvld);
        check_val("ecc_err", ppe_ecc_err, x.err);
        if (x.exact) check_val("latency", cyc - x.cyc, 3);
        // with all five sources busy the grant is the source at the pointer
        if (x.rr) begin
          check_val("rr order", ppe_src, rr_ptr);
        end
      end
      // pointer moves one past every granted source
      rr_ptr = (int'(ppe_src) + 1) % NSRC;
    end
  end

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial begin
    repeat (TBL_LEN * 20 + 200) @(posedge clk);
    $display("timeout: the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    clk = 1'b0;
    rst = 1'b1;
    errors = 0;
    cyc = 0;
    lcg_state = 32'habd2_08f5;
    xoff_s = 1'b0;
    xoff_seen = 1'b0;
    rr_ptr = 0;
    for (int s = 0; s < NSRC; s++) begin
      rx_ecc[s] = '0;
      rx_port[s] = '0;
      rx_dv[s] = '0;
      rx_md[s] = '0;
      rx_ts[s] = '0;
      rx_data[s] = '0;
      rx_xoff[s] = 1'b0;
      rx_tc[s] = '0;
    end

    // srcs, port, md, mask, corrupt, gap, exact, rr
    // single beats on idle sources, masking and check codes
    tbl[0]  = '{5'b00001, 2'd1, 16'h1111, 2'b11, 2'b00, 4'd8, 1'b1, 1'b0};
    tbl[1]  = '{5'b00100, 2'd2, 16'h2222, 2'b01, 2'b00, 4'd8, 1'b1, 1'b0};
    tbl[2]  = '{5'b01000, 2'd3, 16'h3333, 2'b11, 2'b01, 4'd8, 1'b1, 1'b0};
    tbl[3]  = '{5'b10000, 2'd0, 16'h4444, 2'b01, 2'b10, 4'd8, 1'b1, 1'b0};
    tbl[4]  = '{5'b00010, 2'd1, 16'h5555, 2'b10, 2'b10, 4'd8, 1'b1, 1'b0};
    // five-way rounds at a rate the arbiter keeps up with
    tbl[5]  = '{5'b11111, 2'd2, 16'h6600, 2'b11, 2'b00, 4'd4, 1'b0, 1'b1};
    tbl[6]  = '{5'b11111, 2'd3, 16'h7700, 2'b11, 2'b00, 4'd4, 1'b0, 1'b1};
    tbl[7]  = '{5'b11111, 2'd0, 16'h8800, 2'b11, 2'b00, 4'd4, 1'b0, 1'b1};
    tbl[8]  = '{5'b11111, 2'd1, 16'h9900, 2'b11, 2'b00, 4'd8, 1'b0, 1'b1};
    // vp burst under contention fills the vp fifo
    tbl[9]  = '{5'b11111, 2'd2, 16'ha000, 2'b11, 2'b00, 4'd0, 1'b0, 1'b0};
    tbl[10] = '{5'b11111, 2'd3, 16'hb000, 2'b11, 2'b00, 4'd0, 1'b0, 1'b0};
    tbl[11] = '{5'b11111, 2'd0, 16'hc000, 2'b11, 2'b01, 4'd0, 1'b0, 1'b0};
    tbl[12] = '{5'b10000, 2'd1, 16'hd000, 2'b11, 2'b00, 4'd2, 1'b0, 1'b0};
    tbl[13] = '{5'b10000, 2'd2, 16'he000, 2'b10, 2'b00, 4'd8, 1'b0, 1'b0};

    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_val("ppe_valid after reset", ppe_valid, 0);
    check_val("xoff after reset", vp_tx_pfc_xoff, 0);
    for (int g = 0; g < 4; g++) check_val("pause after reset", pause[g], 0);

    for (int i = 0; i < TBL_LEN; i++) apply_entry(tbl[i]);

    while (outstanding() > 0) @(negedge clk);
    repeat (5) @(negedge clk);
    if (!xoff_seen) begin
      errors++;
      $display("vp_tx_pfc_xoff never rose during the vp burst");
    end
    check_val("xoff after drain", vp_tx_pfc_xoff, 0);

    for (int g = 0; g < 4; g++) pause_check(g);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
